//--- include/mam_config.svh
`ifndef MAM_CONFIG_SVH
`define MAM_CONFIG_SVH

// Memory port geometry
`define MAM_DATA_WIDTH 32                      // Multiple of 16
`define MAM_ADDR_WIDTH 32
`define MAM_ADDR_WORDS (`MAM_ADDR_WIDTH / 16)  // Address flits per request
`define MAM_WORD_FLITS (`MAM_DATA_WIDTH / 16)  // Flits per memory word

// Debug packet framing
`define MAM_MAX_PKT_LEN 8                      // Header included
`define MAM_HDR_FLITS 3                        // Dest, src, flags

// Flags word, TYPE = EVENT and no subtype
`define MAM_FLAGS_EVENT 16'h8000

// Burst length counter
`define MAM_BEATS_WIDTH 13

`endif

//--- rtl/mam_pkg.sv
`default_nettype none

`include "mam_config.svh"

package mam_pkg;

  ////////////////////////////////////////
  // Debug interconnect flit
  ////////////////////////////////////////
  typedef struct packed {
    logic        valid;
    logic        last;   // Final flit of a packet
    logic [15:0] data;
  } dii_flit_t;

  ////////////////////////////////////////
  // Decoded memory access
  ////////////////////////////////////////
  typedef struct packed {
    logic                          we;     // 1 write, 0 read
    logic                          burst;
    logic                          sync;   // Acknowledge after write_complete
    logic [15:0]                   src;    // Requester id, reply destination
    logic [`MAM_BEATS_WIDTH-1:0]   beats;
    logic [`MAM_DATA_WIDTH/8-1:0]  strb;
    logic [`MAM_ADDR_WIDTH-1:0]    addr;
  } mam_cmd_t;

  // Read data cut into flits
  typedef struct packed {
    logic [15:0] data;
    logic        final_flit;  // Last flit of the whole transfer
  } mam_stream_t;

endpackage

`default_nettype wire

//--- rtl/mam_cmd_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "mam_config.svh"

module mam_cmd_decode (
  input  wire                clk,
  input  wire                rst,
  input  mam_pkg::dii_flit_t debug_in,
  output logic               debug_in_ready,
  output mam_pkg::dii_flit_t payload,
  input  wire                payload_ready,
  output logic               req_valid,
  input  wire                req_ready,
  output mam_pkg::mam_cmd_t  cmd,
  output logic               cmd_start,
  input  wire                txn_done
);

  localparam int AW    = `MAM_ADDR_WIDTH;
  localparam int BW    = `MAM_BEATS_WIDTH;
  localparam int SW    = `MAM_DATA_WIDTH / 8;
  localparam int POS_W = $clog2(`MAM_ADDR_WORDS + `MAM_HDR_FLITS);
  localparam int REM_W = `MAM_BEATS_WIDTH + $clog2(`MAM_WORD_FLITS);

  typedef enum logic [3:0] {
    S_DEST, S_SRC, S_FLAGS, S_HDR, S_ADDR, S_REQ, S_PAYLOAD, S_SKIP, S_WAIT
  } state_t;

  state_t           state;
  logic [POS_W-1:0] pos;       // Address or continuation header position
  logic [REM_W-1:0] rem;       // Payload flits still expected
  logic             pkt_end;   // Address ended its packet
  logic             in_fire;

  always_comb begin
    case (state)
      S_REQ, S_WAIT: debug_in_ready = 1'b0;
      S_PAYLOAD:     debug_in_ready = payload_ready;  // Back-pressure from write path
      default:       debug_in_ready = 1'b1;
    endcase
  end

  assign in_fire   = debug_in.valid && debug_in_ready;
  assign req_valid = (state == S_REQ);
  assign cmd_start = req_valid && req_ready;

  always_comb begin
    payload.valid = debug_in.valid && (state == S_PAYLOAD);
    payload.last  = debug_in.last;
    payload.data  = debug_in.data;
  end

  ////////////////////////////////////////
  // Packet walker
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_DEST;
      pos     <= '0;
      rem     <= '0;
      pkt_end <= 1'b0;
    end else begin
      case (state)
        S_DEST:  if (in_fire) state <= S_SRC;
        S_SRC:   if (in_fire) state <= S_FLAGS;
        S_FLAGS: if (in_fire) state <= S_HDR;
        S_HDR: begin
          if (in_fire) begin
            pos   <= '0;
            state <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (in_fire) begin
            pos <= pos + 1'b1;
            if (pos == POS_W'(`MAM_ADDR_WORDS - 1)) begin
              pkt_end <= debug_in.last;
              state   <= S_REQ;
            end
          end
        end
        S_REQ: begin
          if (req_ready) begin
            rem <= REM_W'(cmd.beats * `MAM_WORD_FLITS);
            pos <= '0;
            if (!cmd.we)
              state <= S_WAIT;   // Read needs no more input
            else if (pkt_end)
              state <= S_SKIP;   // Payload starts in next packet
            else
              state <= S_PAYLOAD;
          end
        end
        S_PAYLOAD: begin
          if (in_fire) begin
            rem <= rem - 1'b1;
            if (rem == REM_W'(1)) begin
              state <= S_WAIT;
            end else if (debug_in.last) begin
              pos   <= '0;
              state <= S_SKIP;
            end
          end
        end
        S_SKIP: begin
          if (in_fire) begin
            pos <= pos + 1'b1;
            if (pos == POS_W'(`MAM_HDR_FLITS - 1))
              state <= S_PAYLOAD;
          end
        end
        S_WAIT:  if (txn_done) state <= S_DEST;
        default: state <= S_DEST;
      endcase
    end
  end

  // Command fields captured from the request header
  always_ff @(posedge clk) begin
    if (in_fire) begin
      case (state)
        S_SRC: cmd.src <= debug_in.data;
        S_HDR: begin
          cmd.we    <= debug_in.data[15];
          cmd.burst <= debug_in.data[14];
          cmd.sync  <= debug_in.data[13];
          cmd.beats <= debug_in.data[14] ? BW'(debug_in.data[7:0]) : BW'(1);
          cmd.strb  <= debug_in.data[SW-1:0];
        end
        S_ADDR: cmd.addr <= AW'({cmd.addr, debug_in.data});  // MSB flit first
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/mam_write_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "mam_config.svh"

module mam_write_path (
  input  wire                                clk,
  input  wire                                rst,
  input  mam_pkg::mam_cmd_t                  cmd,
  input  wire                                cmd_start,
  input  mam_pkg::dii_flit_t                 payload,
  output logic                               payload_ready,
  output logic                               write_valid,
  output logic [`MAM_DATA_WIDTH-1:0]         write_data,
  output logic [`MAM_DATA_WIDTH/8-1:0]       write_strb,
  input  wire                                write_ready,
  output logic                               writes_done
);

  localparam int DW     = `MAM_DATA_WIDTH;
  localparam int BW     = `MAM_BEATS_WIDTH;
  localparam int WCNT_W = (`MAM_WORD_FLITS > 1) ? $clog2(`MAM_WORD_FLITS) : 1;

  logic              active;
  logic [WCNT_W-1:0] word_cnt;     // Flits already in the word
  logic [BW-1:0]     beats_left;
  logic [DW-1:0]     word;
  logic              pl_fire;
  logic              wr_fire;

  // No new flits while a word waits on the memory
  assign payload_ready = active && !write_valid;
  assign pl_fire       = payload.valid && payload_ready;
  assign wr_fire       = write_valid && write_ready;

  assign write_data = word;
  assign write_strb = cmd.strb;

  ////////////////////////////////////////
  // Beat control
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      active      <= 1'b0;
      word_cnt    <= '0;
      beats_left  <= '0;
      write_valid <= 1'b0;
      writes_done <= 1'b0;
    end else begin
      writes_done <= 1'b0;

      if (cmd_start && cmd.we) begin
        active     <= 1'b1;
        word_cnt   <= '0;
        beats_left <= cmd.beats;
      end

      if (pl_fire) begin
        if (word_cnt == WCNT_W'(`MAM_WORD_FLITS - 1)) begin
          word_cnt    <= '0;
          write_valid <= 1'b1;   // Word complete
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end

      if (wr_fire) begin
        write_valid <= 1'b0;
        beats_left  <= beats_left - 1'b1;
        if (beats_left == BW'(1)) begin
          active      <= 1'b0;
          writes_done <= 1'b1;
        end
      end
    end
  end

  // Big-endian assembly, first flit ends up on top
  always_ff @(posedge clk) begin
    if (pl_fire)
      word <= DW'({word, payload.data});
  end

endmodule

`default_nettype wire

//--- rtl/mam_read_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "mam_config.svh"

module mam_read_path (
  input  wire                         clk,
  input  wire                         rst,
  input  mam_pkg::mam_cmd_t           cmd,
  input  wire                         cmd_start,
  input  wire                         read_valid,
  input  wire [`MAM_DATA_WIDTH-1:0]   read_data,
  output logic                        read_ready,
  output mam_pkg::mam_stream_t        rd_stream,
  output logic                        rd_valid,
  input  wire                         rd_ready
);

  localparam int DW     = `MAM_DATA_WIDTH;
  localparam int BW     = `MAM_BEATS_WIDTH;
  localparam int WCNT_W = (`MAM_WORD_FLITS > 1) ? $clog2(`MAM_WORD_FLITS) : 1;

  logic              active;
  logic [WCNT_W-1:0] slice;        // Current flit within the word
  logic [BW-1:0]     beats_left;
  logic              last_slice;
  logic              rd_fire;

  assign last_slice = (slice == WCNT_W'(`MAM_WORD_FLITS - 1));
  assign rd_valid   = active && read_valid;
  assign rd_fire    = rd_valid && rd_ready;
  assign read_ready = rd_fire && last_slice;   // Word fully consumed

  always_comb begin
    rd_stream.data       = read_data[DW - 1 - 16 * int'(slice) -: 16];  // MSB first
    rd_stream.final_flit = last_slice && (beats_left == BW'(1));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      active     <= 1'b0;
      slice      <= '0;
      beats_left <= '0;
    end else if (cmd_start && !cmd.we) begin
      active     <= 1'b1;
      slice      <= '0;
      beats_left <= cmd.beats;
    end else if (rd_fire) begin
      if (last_slice) begin
        slice      <= '0;
        beats_left <= beats_left - 1'b1;
        if (beats_left == BW'(1))
          active <= 1'b0;
      end else begin
        slice <= slice + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/mam_resp_packer.sv
`timescale 1ns/10ps
`default_nettype none

`include "mam_config.svh"

module mam_resp_packer (
  input  wire                  clk,
  input  wire                  rst,
  input  wire [15:0]           id,
  input  mam_pkg::mam_cmd_t    cmd,
  input  wire                  cmd_start,
  input  mam_pkg::mam_stream_t rd_stream,
  input  wire                  rd_valid,
  output logic                 rd_ready,
  input  wire                  writes_done,
  input  wire                  write_complete,
  output mam_pkg::dii_flit_t   debug_out,
  input  wire                  debug_out_ready,
  output logic                 txn_done
);

  localparam int HCNT_W   = $clog2(`MAM_HDR_FLITS);
  localparam int DATA_MAX = `MAM_MAX_PKT_LEN - `MAM_HDR_FLITS;  // Data flits per packet
  localparam int DCNT_W   = $clog2(DATA_MAX);

  typedef enum logic [2:0] {
    P_IDLE, P_RD_HDR, P_RD_DATA, P_WR_WAIT, P_SYNC_WAIT, P_ACK
  } state_t;

  state_t            state;
  logic [HCNT_W-1:0] hdr_cnt;
  logic [DCNT_W-1:0] data_cnt;
  logic [15:0]       hdr_word;
  logic              hdr_last;
  logic              pkt_full;
  logic              out_fire;

  assign hdr_last = (hdr_cnt == HCNT_W'(`MAM_HDR_FLITS - 1));
  assign pkt_full = (data_cnt == DCNT_W'(DATA_MAX - 1));
  assign out_fire = debug_out.valid && debug_out_ready;

  always_comb begin
    case (hdr_cnt)
      HCNT_W'(0): hdr_word = cmd.src;  // Reply goes back to requester
      HCNT_W'(1): hdr_word = id;
      default:    hdr_word = `MAM_FLAGS_EVENT;
    endcase
  end

  ////////////////////////////////////////
  // Outgoing flit mux
  ////////////////////////////////////////
  always_comb begin
    debug_out = '0;
    rd_ready  = 1'b0;
    case (state)
      P_RD_HDR, P_ACK: begin
        debug_out.valid = 1'b1;
        debug_out.data  = hdr_word;
        debug_out.last  = (state == P_ACK) && hdr_last;  // Ack is header only
      end
      P_RD_DATA: begin
        debug_out.valid = rd_valid;
        debug_out.data  = rd_stream.data;
        debug_out.last  = pkt_full || rd_stream.final_flit;
        rd_ready        = debug_out_ready;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= P_IDLE;
      hdr_cnt  <= '0;
      data_cnt <= '0;
      txn_done <= 1'b0;
    end else begin
      txn_done <= 1'b0;
      case (state)
        P_IDLE: begin
          if (cmd_start) begin
            hdr_cnt <= '0;
            state   <= cmd.we ? P_WR_WAIT : P_RD_HDR;
          end
        end
        P_RD_HDR: begin
          if (out_fire) begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_last) begin
              data_cnt <= '0;
              state    <= P_RD_DATA;
            end
          end
        end
        P_RD_DATA: begin
          if (out_fire) begin
            data_cnt <= data_cnt + 1'b1;
            if (rd_stream.final_flit) begin
              txn_done <= 1'b1;
              state    <= P_IDLE;
            end else if (pkt_full) begin
              hdr_cnt <= '0;     // More data, new header
              state   <= P_RD_HDR;
            end
          end
        end
        P_WR_WAIT: begin
          if (writes_done) begin
            if (cmd.sync) begin
              state <= P_SYNC_WAIT;
            end else begin
              txn_done <= 1'b1;
              state    <= P_IDLE;
            end
          end
        end
        P_SYNC_WAIT: if (write_complete) state <= P_ACK;
        P_ACK: begin
          if (out_fire) begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_last) begin
              txn_done <= 1'b1;
              state    <= P_IDLE;
            end
          end
        end
        default: state <= P_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/mam_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mam_config.svh"

module mam_top (
  input  wire                             clk,
  input  wire                             rst,
  input  wire [15:0]                      id,

  input  mam_pkg::dii_flit_t              debug_in,
  output logic                            debug_in_ready,
  output mam_pkg::dii_flit_t              debug_out,
  input  wire                             debug_out_ready,

  output logic                            req_valid,
  input  wire                             req_ready,
  output logic                            req_we,
  output logic [`MAM_ADDR_WIDTH-1:0]      req_addr,
  output logic                            req_burst,
  output logic [`MAM_BEATS_WIDTH-1:0]     req_beats,
  output logic                            req_sync,

  output logic                            write_valid,
  input  wire                             write_ready,
  output logic [`MAM_DATA_WIDTH-1:0]      write_data,
  output logic [`MAM_DATA_WIDTH/8-1:0]    write_strb,
  input  wire                             write_complete,

  input  wire                             read_valid,
  output logic                            read_ready,
  input  wire [`MAM_DATA_WIDTH-1:0]       read_data
);

  mam_pkg::mam_cmd_t    cmd;
  mam_pkg::dii_flit_t   payload;
  mam_pkg::mam_stream_t rd_stream;
  logic                 cmd_start;
  logic                 payload_ready;
  logic                 rd_valid;
  logic                 rd_ready;
  logic                 writes_done;
  logic                 txn_done;

  // Request fields straight from the decoded command
  assign req_we    = cmd.we;
  assign req_addr  = cmd.addr;
  assign req_burst = cmd.burst;
  assign req_beats = cmd.beats;
  assign req_sync  = cmd.sync;

  mam_cmd_decode u_decode (
    .clk, .rst, .debug_in, .debug_in_ready, .payload, .payload_ready,
    .req_valid, .req_ready, .cmd, .cmd_start, .txn_done
  );

  mam_write_path u_write (
    .clk, .rst, .cmd, .cmd_start, .payload, .payload_ready,
    .write_valid, .write_data, .write_strb, .write_ready, .writes_done
  );

  mam_read_path u_read (
    .clk, .rst, .cmd, .cmd_start, .read_valid, .read_data, .read_ready,
    .rd_stream, .rd_valid, .rd_ready
  );

  mam_resp_packer u_resp (
    .clk, .rst, .id, .cmd, .cmd_start, .rd_stream, .rd_valid, .rd_ready,
    .writes_done, .write_complete, .debug_out, .debug_out_ready, .txn_done
  );

endmodule

`default_nettype wire

//--- sim/tb_mam.sv
`timescale 1ns/10ps
`default_nettype none

`include "mam_config.svh"

module tb_mam;

  localparam int PERIOD  = 40;
  localparam int NUM_TXN = 200;
  localparam int DW      = `MAM_DATA_WIDTH;
  localparam int AW      = `MAM_ADDR_WIDTH;

  logic                   clk;
  logic                   rst;
  logic [15:0]            id;
  mam_pkg::dii_flit_t     debug_in;
  logic                   debug_in_ready;
  mam_pkg::dii_flit_t     debug_out;
  logic                   debug_out_ready;
  logic                   req_valid;
  logic                   req_ready;
  logic                   req_we;
  logic [AW-1:0]          req_addr;
  logic                   req_burst;
  logic [`MAM_BEATS_WIDTH-1:0] req_beats;
  logic                   req_sync;
  logic                   write_valid;
  logic                   write_ready;
  logic [DW-1:0]          write_data;
  logic [DW/8-1:0]        write_strb;
  logic                   write_complete;
  logic                   read_valid;
  logic                   read_ready;
  logic [DW-1:0]          read_data;

  // Expected transaction state, shared with the monitor
  logic                   exp_we;
  logic                   exp_burst;
  logic                   exp_sync;
  logic [AW-1:0]          exp_addr;
  logic [`MAM_BEATS_WIDTH-1:0] exp_beats;
  logic [DW/8-1:0]        exp_strb;
  logic [DW-1:0]          exp_words[$];   // Write words still to come
  logic [16:0]            exp_out[$];     // {last, data} per output flit
  logic [DW-1:0]          mem[logic [AW-1:0]];
  int                     req_cnt;
  int                     wr_cnt;
  int                     rd_beat;
  logic                   wc_seen;
  logic [31:0]            stim_state;
  logic [31:0]            stall_state;

  mam_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function logic [15:0] next_rand16();
    stim_state = lcg(stim_state);
    return stim_state[31:16];
  endfunction

  // Untouched words hold a pattern of their address
  function automatic logic [DW-1:0] mem_value(input logic [AW-1:0] addr);
    if (mem.exists(addr))
      return mem[addr];
    return DW'(addr * 32'h9e3779b1) ^ DW'({addr[15:0], addr[31:16]});
  endfunction

  task automatic store_word(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                            input logic [DW/8-1:0] strb);
    logic [DW-1:0] merged;
    merged = mem_value(addr);
    for (int j = 0; j < DW / 8; j++)
      if (strb[j]) merged[8*j +: 8] = data[8*j +: 8];
    mem[addr] = merged;
  endtask

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  ////////////////////////////////////////
  // Stalls and read data, one LCG draw per cycle
  ////////////////////////////////////////
  always @(negedge clk) begin
    stall_state     = lcg(stall_state);
    req_ready       = stall_state[17:16] != 2'b00;
    write_ready     = stall_state[19:18] != 2'b00;
    debug_out_ready = stall_state[21:20] != 2'b00;
    write_complete  = stall_state[23:22] == 2'b00;
    if (!exp_we && req_cnt == 1 && rd_beat < int'(exp_beats)) begin
      read_valid = stall_state[25:24] != 2'b00;
      read_data  = mem_value(exp_addr + AW'(rd_beat));  // Same word until consumed
    end else begin
      read_valid = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Monitor, samples between edges
  ////////////////////////////////////////
  always begin
    logic [16:0] front;
    @(negedge clk);
    #1;
    if (!rst) begin
      if (req_valid && req_ready) begin
        assert (req_cnt == 0) else report_mismatch("second memory request in one packet");
        assert (req_we == exp_we && req_burst == exp_burst && req_sync == exp_sync &&
                req_addr == exp_addr && req_beats == exp_beats)
          else report_mismatch($sformatf("request we=%b addr=%h beats=%0d, exp %b %h %0d",
                                         req_we, req_addr, req_beats, exp_we, exp_addr,
                                         exp_beats));
        req_cnt++;
      end
      if (write_valid && write_ready) begin
        assert (exp_words.size() > 0) else report_mismatch("write beat beyond burst length");
        assert (write_data == exp_words[0] && write_strb == exp_strb)
          else report_mismatch($sformatf("write data %h strb %h, exp %h %h", write_data,
                                         write_strb, exp_words[0], exp_strb));
        store_word(exp_addr + AW'(wr_cnt), write_data, write_strb);
        exp_words.delete(0);
        wr_cnt++;
      end
      if (read_valid && read_ready)
        rd_beat++;
      if (write_complete && exp_we && wr_cnt == int'(exp_beats))
        wc_seen = 1'b1;
      if (debug_out.valid && debug_out_ready) begin
        assert (exp_out.size() > 0) else report_mismatch("output flit not expected");
        front = exp_out.pop_front();
        assert ({debug_out.last, debug_out.data} == front)
          else report_mismatch($sformatf("out flit last=%b data=%h, exp last=%b data=%h",
                                         debug_out.last, debug_out.data, front[16],
                                         front[15:0]));
        if (exp_we) begin
          assert (wc_seen) else report_failure("acknowledge sent before write_complete");
        end
      end
    end
  end

  // Hold a flit until the DUT takes it
  task automatic send_flit(input logic [15:0] data, input logic last);
    logic acc;
    @(negedge clk);
    debug_in.valid = 1'b1;
    debug_in.last  = last;
    debug_in.data  = data;
    acc = 1'b0;
    while (!acc) begin
      #1;
      acc = debug_in_ready;
      if (!acc) @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic run_txn();
    logic [15:0] r;
    logic [15:0] hdr;
    logic [15:0] src;
    logic [15:0] addr_lo;
    logic [DW-1:0] w;
    logic [15:0] pl[$];
    logic [15:0] rd_flits[$];
    int cnt;
    int k;
    logic brk;
    r         = next_rand16();
    exp_we    = r[0];
    exp_burst = r[1];
    exp_sync  = r[2];
    src       = next_rand16();
    addr_lo   = next_rand16();
    exp_addr  = {16'h4000, 8'h00, addr_lo[7:0]};  // Narrow range, words get reused
    hdr       = {exp_we, exp_burst, exp_sync, r[7:3], 8'h00};
    hdr[7:0]  = exp_burst ? 8'(1 + r[15:8] % 12) : r[15:8];
    exp_beats = exp_burst ? `MAM_BEATS_WIDTH'(hdr[7:0]) : `MAM_BEATS_WIDTH'(1);
    exp_strb  = hdr[DW/8-1:0];
    req_cnt   = 0;
    wr_cnt    = 0;
    rd_beat   = 0;
    wc_seen   = 1'b0;
    exp_words.delete();
    exp_out.delete();

    if (exp_we) begin
      for (int b = 0; b < int'(exp_beats); b++) begin
        w = DW'({next_rand16(), next_rand16()});
        exp_words.push_back(w);
        for (int s = 0; s < DW / 16; s++)
          pl.push_back(w[DW-1-16*s -: 16]);
      end
      if (exp_sync) begin
        exp_out.push_back({1'b0, src});
        exp_out.push_back({1'b0, id});
        exp_out.push_back({1'b1, 16'h8000});
      end
    end else begin
      for (int b = 0; b < int'(exp_beats); b++) begin
        w = mem_value(exp_addr + AW'(b));
        for (int s = 0; s < DW / 16; s++)
          rd_flits.push_back(w[DW-1-16*s -: 16]);
      end
      k = 0;
      while (k < rd_flits.size()) begin
        exp_out.push_back({1'b0, src});
        exp_out.push_back({1'b0, id});
        exp_out.push_back({1'b0, 16'h8000});
        cnt = 0;
        while (k < rd_flits.size() && cnt < 5) begin
          exp_out.push_back({cnt == 4 || k == rd_flits.size() - 1, rd_flits[k]});
          k++;
          cnt++;
        end
      end
    end

    send_flit(next_rand16(), 1'b0);   // Destination
    send_flit(src, 1'b0);
    send_flit(next_rand16(), 1'b0);   // Flags
    send_flit(hdr, 1'b0);
    send_flit(exp_addr[31:16], 1'b0);
    brk = !exp_we || (next_rand16() % 4 == 0);
    send_flit(exp_addr[15:0], brk);
    for (int i = 0; i < pl.size(); i++) begin
      if (brk)
        repeat (3) send_flit(next_rand16(), 1'b0);  // Continuation header
      brk = (i == pl.size() - 1) || (next_rand16() % 4 == 0);
      send_flit(pl[i], brk);
    end

    @(negedge clk);
    debug_in = '0;
    #2;
    while (!debug_in_ready) begin
      @(negedge clk);
      #2;
    end
    assert (req_cnt == 1) else report_mismatch("no memory request for packet");
    assert (exp_words.size() == 0 && exp_out.size() == 0)
      else report_mismatch("transaction ended with data outstanding");
    if (exp_we) begin
      assert (wr_cnt == int'(exp_beats)) else report_mismatch("write beat count");
    end else begin
      assert (rd_beat == int'(exp_beats)) else report_mismatch("read beat count");
    end
  endtask

  initial begin
    rst             = 1'b1;
    id              = 16'h3a7c;
    debug_in        = '0;
    debug_out_ready = 1'b0;
    req_ready       = 1'b0;
    write_ready     = 1'b0;
    write_complete  = 1'b0;
    read_valid      = 1'b0;
    read_data       = '0;
    exp_we          = 1'b0;
    exp_addr        = '0;
    exp_beats       = '0;
    req_cnt         = 0;
    wr_cnt          = 0;
    rd_beat         = 0;
    wc_seen         = 1'b0;
    stim_state      = 32'h24d0;
    stall_state     = lcg(32'h24d0 ^ 32'hffff_0000);
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #2;
    assert (!req_valid && !write_valid && !read_ready && !debug_out.valid && debug_in_ready)
      else report_mismatch("control outputs not idle after reset");

    for (int t = 0; t < NUM_TXN; t++)
      run_txn();

    $display("NO ERRORS");
    $finish;
  end

  // Watchdog
  initial begin
    #(longint'(NUM_TXN) * 2000 * PERIOD);
    report_failure("Timeout: transactions did not complete in time");
  end

endmodule

`default_nettype wire

//--- mam.f
+incdir+include
rtl/mam_pkg.sv
rtl/mam_cmd_decode.sv
rtl/mam_write_path.sv
rtl/mam_read_path.sv
rtl/mam_resp_packer.sv
rtl/mam_top.sv
sim/tb_mam.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the debug memory access testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f mam.f --top-module tb_mam -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_mam
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit 1
fi

echo "Simulation finished"
exit 0
